// ==== design/gpio_consts.svh ====
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

////////////////////////////////////////
// Data path sizing
////////////////////////////////////////

// Pin count and APB data width
// Has to stay a multiple of 8
`define GPIO_DATA_W 32

// One strobe bit per byte lane
`define GPIO_STRB_W (`GPIO_DATA_W / 8)

////////////////////////////////////////
// Address and input path
////////////////////////////////////////

// Word index into the register map
`define GPIO_ADDR_W 4

// Flip-flops in front of the input register
`define GPIO_SYNC_STAGES 2

`endif

// ==== design/gpio_pkg.sv ====
`include "gpio_consts.svh"

package gpio_pkg;

  // One bit per pin
  typedef logic [`GPIO_DATA_W-1:0] gpio_word_t;

  // One bit per byte lane
  typedef logic [`GPIO_STRB_W-1:0] gpio_strb_t;

  // Word index, PADDR without the byte offset
  typedef logic [`GPIO_ADDR_W-1:0] gpio_addr_t;

  // Register map
  typedef enum gpio_addr_t {
    REG_MODE    = 4'd0,
    REG_DIR     = 4'd1,
    REG_OUT     = 4'd2,
    REG_IN      = 4'd3,
    REG_TR_TYPE = 4'd4,
    REG_TR_LVL0 = 4'd5,
    REG_TR_LVL1 = 4'd6,
    REG_TR_STAT = 4'd7,
    REG_IRQ_ENA = 4'd8
  } gpio_reg_e;

  // Output driver kind, one bit of the mode register
  typedef enum logic {DRIVE_PUSH_PULL = 1'b0, DRIVE_OPEN_DRAIN = 1'b1} gpio_drive_e;

  // Trigger kind, one bit of the trigger type register
  typedef enum logic {TRIG_LEVEL = 1'b0, TRIG_EDGE = 1'b1} gpio_trig_e;

endpackage

// ==== design/gpio_apb_regs.sv ====
`include "gpio_consts.svh"

module gpio_apb_regs (
  input  logic                 PCLK,
  input  logic                 PRESETn,

  // APB slave side
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  gpio_pkg::gpio_addr_t paddr,
  input  gpio_pkg::gpio_strb_t pstrb,
  input  gpio_pkg::gpio_word_t pwdata,
  output gpio_pkg::gpio_word_t prdata,

  // From the pad and trigger logic
  input  gpio_pkg::gpio_word_t in_val,
  input  gpio_pkg::gpio_word_t tr_hit,

  // Configuration words
  output gpio_pkg::gpio_word_t mode,
  output gpio_pkg::gpio_word_t dir,
  output gpio_pkg::gpio_word_t out_val,
  output gpio_pkg::gpio_word_t tr_type,
  output gpio_pkg::gpio_word_t tr_lvl0,
  output gpio_pkg::gpio_word_t tr_lvl1,

  output logic                 irq
);

  ////////////////////////////////////////
  // Sizing check
  ////////////////////////////////////////

  // Byte lanes must cover the word exactly
  if ((`GPIO_STRB_W * 8) != `GPIO_DATA_W) begin : g_width_check
    $error("GPIO data width must be a multiple of 8");
  end

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // Registers kept inside this block
  gpio_pkg::gpio_word_t tr_stat;
  gpio_pkg::gpio_word_t irq_ena;

  // Write decode
  logic                 wr_en;
  gpio_pkg::gpio_reg_e  reg_idx;

  // Strobes widened to one bit per data bit
  gpio_pkg::gpio_word_t byte_mask;

  // Bits cleared in the status word this cycle
  gpio_pkg::gpio_word_t stat_clr;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Strobed bytes come from the bus
  // Other bytes keep their old value
  function automatic gpio_pkg::gpio_word_t merge_bytes(
    input gpio_pkg::gpio_word_t old_val,
    input gpio_pkg::gpio_word_t new_val,
    input gpio_pkg::gpio_word_t lane_mask
  );
    return (old_val & ~lane_mask) | (new_val & lane_mask);
  endfunction

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Write lands in the access phase
  assign wr_en   = psel & penable & pwrite;
  // Unmapped indices fall into the default arms below
  assign reg_idx = gpio_pkg::gpio_reg_e'(paddr);

  always_comb begin
    for (int i = 0; i < `GPIO_STRB_W; i++) begin
      byte_mask[i*8 +: 8] = {8{pstrb[i]}};
    end
  end

  ////////////////////////////////////////
  // Configuration writes
  ////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      mode    <= '0;
      dir     <= '0;
      out_val <= '0;
      tr_type <= '0;
      tr_lvl0 <= '0;
      tr_lvl1 <= '0;
      irq_ena <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        gpio_pkg::REG_MODE:    mode    <= merge_bytes(mode, pwdata, byte_mask);
        gpio_pkg::REG_DIR:     dir     <= merge_bytes(dir, pwdata, byte_mask);
        // Input index is read-only, so a write goes to the output word
        gpio_pkg::REG_OUT,
        gpio_pkg::REG_IN:      out_val <= merge_bytes(out_val, pwdata, byte_mask);
        gpio_pkg::REG_TR_TYPE: tr_type <= merge_bytes(tr_type, pwdata, byte_mask);
        gpio_pkg::REG_TR_LVL0: tr_lvl0 <= merge_bytes(tr_lvl0, pwdata, byte_mask);
        gpio_pkg::REG_TR_LVL1: tr_lvl1 <= merge_bytes(tr_lvl1, pwdata, byte_mask);
        gpio_pkg::REG_IRQ_ENA: irq_ena <= merge_bytes(irq_ena, pwdata, byte_mask);
        // Status is handled below
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Sticky trigger status
  ////////////////////////////////////////

  // Ones written on strobed lanes clear
  assign stat_clr = (wr_en && (reg_idx == gpio_pkg::REG_TR_STAT)) ?
                    (pwdata & byte_mask) : '0;

  // A hit in the clearing cycle wins over the clear
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      tr_stat <= '0;
    end else begin
      tr_stat <= (tr_stat & ~stat_clr) | tr_hit;
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////

  // Sampled every edge from the address
  // Data is stable for the whole access phase
  always_ff @(posedge PCLK) begin
    case (reg_idx)
      gpio_pkg::REG_MODE:    prdata <= mode;
      gpio_pkg::REG_DIR:     prdata <= dir;
      gpio_pkg::REG_OUT:     prdata <= out_val;
      gpio_pkg::REG_IN:      prdata <= in_val;
      gpio_pkg::REG_TR_TYPE: prdata <= tr_type;
      gpio_pkg::REG_TR_LVL0: prdata <= tr_lvl0;
      gpio_pkg::REG_TR_LVL1: prdata <= tr_lvl1;
      gpio_pkg::REG_TR_STAT: prdata <= tr_stat;
      gpio_pkg::REG_IRQ_ENA: prdata <= irq_ena;
      default:               prdata <= '0;
    endcase
  end

  ////////////////////////////////////////
  // Interrupt
  ////////////////////////////////////////

  // Any enabled status bit
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      irq <= 1'b0;
    end else begin
      irq <= |(irq_ena & tr_stat);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Master never issues a write without byte lanes
  a_wr_strb_nonzero: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    wr_en |-> (pstrb != '0)
  ) else $error("APB write with an all-zero strobe");

  // Masked interrupt stays low on the following cycle
  a_irq_masked: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    (irq_ena == '0) |=> !irq
  ) else $error("irq high with the interrupt enable register at zero");

endmodule

// ==== design/gpio_pad_ctrl.sv ====
`include "gpio_consts.svh"

module gpio_pad_ctrl (
  input  logic                 PCLK,
  input  logic                 PRESETn,

  // Pins
  input  gpio_pkg::gpio_word_t gpio_in,
  output gpio_pkg::gpio_word_t gpio_out,
  output gpio_pkg::gpio_word_t gpio_oe,

  // Configuration from the register block
  input  gpio_pkg::gpio_word_t mode,
  input  gpio_pkg::gpio_word_t dir,
  input  gpio_pkg::gpio_word_t out_val,

  // Clean input word
  output gpio_pkg::gpio_word_t in_val
);

  // Synchroniser chain, stage 0 faces the pins
  gpio_pkg::gpio_word_t sync_q [`GPIO_SYNC_STAGES];

  ////////////////////////////////////////
  // Input path
  ////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      for (int s = 0; s < `GPIO_SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
      in_val <= '0;
    end else begin
      sync_q[0] <= gpio_in;
      for (int s = 1; s < `GPIO_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      // One more stage after the chain
      in_val <= sync_q[`GPIO_SYNC_STAGES-1];
    end
  end

  ////////////////////////////////////////
  // Output drivers
  ////////////////////////////////////////

  // Open drain only ever pulls low
  // High is released through the enable
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else begin
      for (int n = 0; n < `GPIO_DATA_W; n++) begin
        if (gpio_pkg::gpio_drive_e'(mode[n]) == gpio_pkg::DRIVE_OPEN_DRAIN) begin
          gpio_out[n] <= 1'b0;
          gpio_oe[n]  <= dir[n] & ~out_val[n];
        end else begin
          gpio_out[n] <= out_val[n];
          gpio_oe[n]  <= dir[n];
        end
      end
    end
  end

  // Input pins never see an enabled driver
  a_oe_needs_dir: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    (gpio_oe & ~$past(dir)) == '0
  ) else $error("Output enable set on a pin configured as input");

endmodule

// ==== design/gpio_trigger.sv ====
`include "gpio_consts.svh"

module gpio_trigger (
  input  logic                 PCLK,
  input  logic                 PRESETn,

  // Synchronised pin word
  input  gpio_pkg::gpio_word_t in_val,

  // Trigger configuration
  input  gpio_pkg::gpio_word_t tr_type,
  input  gpio_pkg::gpio_word_t tr_lvl0,
  input  gpio_pkg::gpio_word_t tr_lvl1,

  // Events for this cycle, one per pin
  output gpio_pkg::gpio_word_t tr_hit
);

  // Previous input word
  gpio_pkg::gpio_word_t in_dly;

  // Registered edge words
  gpio_pkg::gpio_word_t rise_q;
  gpio_pkg::gpio_word_t fall_q;

  ////////////////////////////////////////
  // Edge detection
  ////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      in_dly <= '0;
      rise_q <= '0;
      fall_q <= '0;
    end else begin
      in_dly <= in_val;
      rise_q <= in_val & ~in_dly;
      fall_q <= in_dly & ~in_val;
    end
  end

  ////////////////////////////////////////
  // Trigger evaluation
  ////////////////////////////////////////

  // lvl0 selects low or falling
  // lvl1 selects high or rising
  always_comb begin
    for (int n = 0; n < `GPIO_DATA_W; n++) begin
      case (gpio_pkg::gpio_trig_e'(tr_type[n]))
        gpio_pkg::TRIG_EDGE: begin
          tr_hit[n] = (tr_lvl0[n] & fall_q[n]) | (tr_lvl1[n] & rise_q[n]);
        end
        default: begin
          // Level, straight from the input register
          tr_hit[n] = (tr_lvl0[n] & ~in_val[n]) | (tr_lvl1[n] & in_val[n]);
        end
      endcase
    end
  end

  // One direction per pin per cycle
  a_edge_exclusive: assert property (
    @(posedge PCLK) disable iff (!PRESETn)
    (rise_q & fall_q) == '0
  ) else $error("Rising and falling edge on the same pin in one cycle");

endmodule

// ==== design/gpio_top.sv ====
`include "gpio_consts.svh"

module gpio_top (
  input  logic                    PCLK,
  input  logic                    PRESETn,

  // APB-Lite slave
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  gpio_pkg::gpio_addr_t    PADDR,
  input  logic                    PWRITE,
  input  gpio_pkg::gpio_strb_t    PSTRB,
  input  gpio_pkg::gpio_word_t    PWDATA,
  output gpio_pkg::gpio_word_t    PRDATA,
  output logic                    PREADY,
  output logic                    PSLVERR,

  // Pins
  input  logic [`GPIO_DATA_W-1:0] gpio_in,
  output logic [`GPIO_DATA_W-1:0] gpio_out,
  output logic [`GPIO_DATA_W-1:0] gpio_oe,
  output logic                    irq
);

  // Configuration words
  gpio_pkg::gpio_word_t mode;
  gpio_pkg::gpio_word_t dir;
  gpio_pkg::gpio_word_t out_val;
  gpio_pkg::gpio_word_t tr_type;
  gpio_pkg::gpio_word_t tr_lvl0;
  gpio_pkg::gpio_word_t tr_lvl1;

  // Pin state and trigger events
  gpio_pkg::gpio_word_t in_val;
  gpio_pkg::gpio_word_t tr_hit;

  // Zero wait states, no error response
  assign PREADY  = 1'b1;
  assign PSLVERR = 1'b0;

  ////////////////////////////////////////
  // Register block
  ////////////////////////////////////////

  gpio_apb_regs u_regs (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .psel    (PSEL),
    .penable (PENABLE),
    .pwrite  (PWRITE),
    .paddr   (PADDR),
    .pstrb   (PSTRB),
    .pwdata  (PWDATA),
    .prdata  (PRDATA),
    .in_val  (in_val),
    .tr_hit  (tr_hit),
    .mode    (mode),
    .dir     (dir),
    .out_val (out_val),
    .tr_type (tr_type),
    .tr_lvl0 (tr_lvl0),
    .tr_lvl1 (tr_lvl1),
    .irq     (irq)
  );

  ////////////////////////////////////////
  // Pad and trigger logic
  ////////////////////////////////////////

  gpio_pad_ctrl u_pad (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .mode     (mode),
    .dir      (dir),
    .out_val  (out_val),
    .in_val   (in_val)
  );

  gpio_trigger u_trig (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .in_val  (in_val),
    .tr_type (tr_type),
    .tr_lvl0 (tr_lvl0),
    .tr_lvl1 (tr_lvl1),
    .tr_hit  (tr_hit)
  );

endmodule

// ==== bench/gpio_tb.sv ====
`include "gpio_consts.svh"

module gpio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Row kinds of the stimulus table
  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PINS, OP_IRQ, OP_PADS} op_e;

  localparam int MAX_ROWS   = 128;
  localparam int WAIT_LIMIT = 40;

  logic                 PCLK = 1'b0;
  logic                 PRESETn;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  gpio_pkg::gpio_addr_t paddr;
  gpio_pkg::gpio_strb_t pstrb;
  gpio_pkg::gpio_word_t pwdata;
  gpio_pkg::gpio_word_t prdata;
  logic                 pready;
  logic                 pslverr;
  gpio_pkg::gpio_word_t gpio_in;
  gpio_pkg::gpio_word_t gpio_out;
  gpio_pkg::gpio_word_t gpio_oe;
  logic                 irq;

  // Stimulus table with one column per array
  string                row_name [MAX_ROWS];
  op_e                  row_op   [MAX_ROWS];
  gpio_pkg::gpio_addr_t row_addr [MAX_ROWS];
  gpio_pkg::gpio_strb_t row_strb [MAX_ROWS];
  gpio_pkg::gpio_word_t row_data [MAX_ROWS];
  gpio_pkg::gpio_word_t row_exp  [MAX_ROWS];
  int                   n_rows = 0;

  // Expected read value per register index
  gpio_pkg::gpio_word_t shadow [2**`GPIO_ADDR_W];

  logic [31:0]          rng_state = 32'd76697;
  int                   errors = 0;
  int                   checks = 0;

  always #2 PCLK = ~PCLK;

  gpio_top u_gpio_top (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .PSEL     (psel),
    .PENABLE  (penable),
    .PADDR    (paddr),
    .PWRITE   (pwrite),
    .PSTRB    (pstrb),
    .PWDATA   (pwdata),
    .PRDATA   (prdata),
    .PREADY   (pready),
    .PSLVERR  (pslverr),
    .gpio_in  (gpio_in),
    .gpio_out (gpio_out),
    .gpio_oe  (gpio_oe),
    .irq      (irq)
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // xorshift32
  function automatic gpio_pkg::gpio_word_t next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Strobed lanes come from the new data and the others stay
  function automatic gpio_pkg::gpio_word_t lane_merge(input gpio_pkg::gpio_word_t old_val,
      input gpio_pkg::gpio_word_t new_val, input gpio_pkg::gpio_strb_t strb);
    gpio_pkg::gpio_word_t res;
    res = old_val;
    for (int b = 0; b < `GPIO_STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Level pins hit low with lvl0 and high with lvl1
  function automatic gpio_pkg::gpio_word_t level_hits(input gpio_pkg::gpio_word_t pins,
      input gpio_pkg::gpio_word_t tt, input gpio_pkg::gpio_word_t l0,
      input gpio_pkg::gpio_word_t l1);
    return ~tt & ((l0 & ~pins) | (l1 & pins));
  endfunction

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  task automatic add_row(input string name, input op_e op, input gpio_pkg::gpio_addr_t addr,
      input gpio_pkg::gpio_strb_t strb, input gpio_pkg::gpio_word_t data,
      input gpio_pkg::gpio_word_t exp);
    row_name[n_rows] = name;
    row_op[n_rows]   = op;
    row_addr[n_rows] = addr;
    row_strb[n_rows] = strb;
    row_data[n_rows] = data;
    row_exp[n_rows]  = exp;
    n_rows++;
  endtask

  // Status shadow is kept by the caller
  task automatic add_write(input string name, input gpio_pkg::gpio_reg_e r,
      input gpio_pkg::gpio_strb_t strb, input gpio_pkg::gpio_word_t data);
    gpio_pkg::gpio_reg_e dst;
    // Input index aliases the output register on writes
    dst = (r == gpio_pkg::REG_IN) ? gpio_pkg::REG_OUT : r;
    if (r != gpio_pkg::REG_TR_STAT) begin
      shadow[dst] = lane_merge(shadow[dst], data, strb);
    end
    add_row(name, OP_WRITE, r, strb, data, '0);
  endtask

  task automatic add_read(input string name, input gpio_pkg::gpio_addr_t a);
    add_row(name, OP_READ, a, '0, '0, shadow[a]);
  endtask

  task automatic add_pins(input string name, input gpio_pkg::gpio_word_t pins);
    shadow[gpio_pkg::REG_IN] = pins;
    add_row(name, OP_PINS, gpio_pkg::REG_IN, '0, pins, pins);
  endtask

  task automatic build_table();
    gpio_pkg::gpio_reg_e  cfg [6];
    gpio_pkg::gpio_word_t p0;
    gpio_pkg::gpio_word_t p1;
    gpio_pkg::gpio_word_t tt;
    gpio_pkg::gpio_word_t l0;
    gpio_pkg::gpio_word_t l1;
    gpio_pkg::gpio_word_t clr;
    gpio_pkg::gpio_word_t m;
    cfg = '{gpio_pkg::REG_MODE, gpio_pkg::REG_DIR, gpio_pkg::REG_TR_TYPE,
            gpio_pkg::REG_TR_LVL0, gpio_pkg::REG_TR_LVL1, gpio_pkg::REG_IRQ_ENA};
    for (int a = 0; a < 2**`GPIO_ADDR_W; a++) begin
      shadow[a] = '0;
    end
    // Reset values including unmapped indices
    for (int a = 0; a < 2**`GPIO_ADDR_W; a++) begin
      add_read($sformatf("reset_idx%0d", a), gpio_pkg::gpio_addr_t'(a));
    end
    add_row("reset_irq", OP_IRQ, '0, '0, '0, '0);
    // Full-word readback
    for (int i = 0; i < 6; i++) begin
      add_write("rand_write", cfg[i], '1, next_random());
      add_read($sformatf("readback_%s", cfg[i].name()), cfg[i]);
    end
    add_read("unmapped_idx", 4'hC);
    // Partial strobes and the input alias
    add_write("strobe_mode", gpio_pkg::REG_MODE, 4'b0101, next_random());
    add_read("strobe_mode_rd", gpio_pkg::REG_MODE);
    add_write("strobe_lvl1", gpio_pkg::REG_TR_LVL1, 4'b1000, next_random());
    add_read("strobe_lvl1_rd", gpio_pkg::REG_TR_LVL1);
    add_write("write_in", gpio_pkg::REG_IN, '1, next_random());
    add_read("out_after_in", gpio_pkg::REG_OUT);
    add_write("strobe_out", gpio_pkg::REG_OUT, 4'b0110, next_random());
    add_read("strobe_out_rd", gpio_pkg::REG_OUT);
    // Pin drivers with push-pull and open-drain mixed
    add_write("pad_dir", gpio_pkg::REG_DIR, '1, next_random());
    add_write("pad_mode", gpio_pkg::REG_MODE, '1, next_random());
    for (int i = 0; i < 2; i++) begin
      add_write("pad_out", gpio_pkg::REG_OUT, '1, next_random());
      add_row("pads", OP_PADS, '0, '0,
              shadow[gpio_pkg::REG_OUT] & ~shadow[gpio_pkg::REG_MODE],
              shadow[gpio_pkg::REG_DIR] &
              (~shadow[gpio_pkg::REG_MODE] | ~shadow[gpio_pkg::REG_OUT]));
    end
    // Quiet the triggers and then clear status
    add_write("quiet_ena", gpio_pkg::REG_IRQ_ENA, '1, '0);
    add_write("quiet_lvl0", gpio_pkg::REG_TR_LVL0, '1, '0);
    add_write("quiet_lvl1", gpio_pkg::REG_TR_LVL1, '1, '0);
    add_write("stat_clear", gpio_pkg::REG_TR_STAT, '1, '1);
    add_read("stat_cleared", gpio_pkg::REG_TR_STAT);
    p0 = next_random();
    add_pins("pins_p0", p0);
    add_read("in_readback", gpio_pkg::REG_IN);
    // Mixed level and edge triggers
    tt = next_random();
    l0 = next_random();
    l1 = next_random();
    add_write("trig_type", gpio_pkg::REG_TR_TYPE, '1, tt);
    add_write("trig_lvl0", gpio_pkg::REG_TR_LVL0, '1, l0);
    add_write("trig_lvl1", gpio_pkg::REG_TR_LVL1, '1, l1);
    // Status follows the last trigger write one edge later
    add_read("trig_lvl1_rd", gpio_pkg::REG_TR_LVL1);
    shadow[gpio_pkg::REG_TR_STAT] = level_hits(p0, tt, l0, l1);
    add_read("stat_level_p0", gpio_pkg::REG_TR_STAT);
    p1 = next_random();
    add_pins("pins_p1", p1);
    // Edge pins hit falling with lvl0 and rising with lvl1
    shadow[gpio_pkg::REG_TR_STAT] |= level_hits(p1, tt, l0, l1) |
                                     (tt & ((l0 & p0 & ~p1) | (l1 & ~p0 & p1)));
    add_read("stat_after_p1", gpio_pkg::REG_TR_STAT);
    // Partial clear where still-active levels come straight back
    clr = next_random();
    add_write("stat_part_clr", gpio_pkg::REG_TR_STAT, '1, clr);
    shadow[gpio_pkg::REG_TR_STAT] = (shadow[gpio_pkg::REG_TR_STAT] & ~clr) |
                                    level_hits(p1, tt, l0, l1);
    add_read("stat_part_rd", gpio_pkg::REG_TR_STAT);
    add_write("stat_full_clr", gpio_pkg::REG_TR_STAT, '1, '1);
    shadow[gpio_pkg::REG_TR_STAT] = level_hits(p1, tt, l0, l1);
    add_read("stat_full_rd", gpio_pkg::REG_TR_STAT);
    // Interrupt on one high-level pin
    m = gpio_pkg::gpio_word_t'(1) << (next_random() % `GPIO_DATA_W);
    add_write("irq_lvl0", gpio_pkg::REG_TR_LVL0, '1, '0);
    add_write("irq_lvl1", gpio_pkg::REG_TR_LVL1, '1, '0);
    add_write("irq_type", gpio_pkg::REG_TR_TYPE, '1, '0);
    add_write("irq_clr", gpio_pkg::REG_TR_STAT, '1, '1);
    shadow[gpio_pkg::REG_TR_STAT] = '0;
    add_read("irq_stat_zero", gpio_pkg::REG_TR_STAT);
    add_pins("irq_pin_low", p1 & ~m);
    add_write("irq_arm", gpio_pkg::REG_TR_LVL1, '1, m);
    add_write("irq_ena_other", gpio_pkg::REG_IRQ_ENA, '1, ~m);
    add_pins("irq_pin_high", p1 | m);
    shadow[gpio_pkg::REG_TR_STAT] = m;
    add_read("irq_stat_set", gpio_pkg::REG_TR_STAT);
    add_row("irq_masked", OP_IRQ, '0, '0, '0, '0);
    add_write("irq_ena_pin", gpio_pkg::REG_IRQ_ENA, '1, m);
    add_row("irq_rise", OP_IRQ, '0, '0, '0, 1);
    add_pins("irq_pin_release", p1 & ~m);
    add_write("irq_ack", gpio_pkg::REG_TR_STAT, '1, m);
    add_row("irq_fall", OP_IRQ, '0, '0, '0, '0);
    shadow[gpio_pkg::REG_TR_STAT] = '0;
    add_read("irq_stat_done", gpio_pkg::REG_TR_STAT);
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_word(input string name, input gpio_pkg::gpio_word_t exp,
      input gpio_pkg::gpio_word_t act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  // Called in the access phase at a falling edge
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (pready !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge PCLK);
      cycles++;
    end
    if (pready !== 1'b1) begin
      $display("APB slave kept PREADY low for %0d cycles", WAIT_LIMIT);
      errors++;
    end
    if (pslverr !== 1'b0) begin
      $display("APB slave answered with an error response");
      errors++;
    end
  endtask

  task automatic apb_write(input gpio_pkg::gpio_addr_t addr, input gpio_pkg::gpio_strb_t strb,
      input gpio_pkg::gpio_word_t data);
    // Setup phase
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pstrb   = strb;
    pwdata  = data;
    @(negedge PCLK);
    // Access phase
    penable = 1'b1;
    wait_ready();
    @(negedge PCLK);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input gpio_pkg::gpio_addr_t addr, output gpio_pkg::gpio_word_t data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    penable = 1'b0;
    paddr   = addr;
    pstrb   = '0;
    @(negedge PCLK);
    penable = 1'b1;
    wait_ready();
    // PRDATA is stable through the access phase
    data = prdata;
    @(negedge PCLK);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Drive the pins and poll the input register until it follows
  task automatic settle_pins(input string name, input gpio_pkg::gpio_word_t pins);
    gpio_pkg::gpio_word_t seen;
    int polls;
    gpio_in = pins;
    polls   = 0;
    seen    = ~pins;
    while (seen !== pins && polls < WAIT_LIMIT) begin
      apb_read(gpio_pkg::REG_IN, seen);
      polls++;
    end
    if (seen !== pins) begin
      $display("%s: pin word never reached the input register after %0d reads", name, polls);
      errors++;
    end
  endtask

  task automatic wait_irq(input string name, input logic level);
    int cycles;
    cycles = 0;
    while (irq !== level && cycles < WAIT_LIMIT) begin
      @(negedge PCLK);
      cycles++;
    end
    if (irq !== level) begin
      $display("%s: irq did not reach %b within %0d cycles", name, level, WAIT_LIMIT);
    end
    check_irq(name, level, irq);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    gpio_pkg::gpio_word_t rdata;
    PRESETn = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pstrb   = '0;
    pwdata  = '0;
    gpio_in = '0;
    build_table();
    repeat (10) @(negedge PCLK);
    PRESETn = 1'b1;
    @(negedge PCLK);
    for (int i = 0; i < n_rows; i++) begin
      case (row_op[i])
        OP_WRITE: apb_write(row_addr[i], row_strb[i], row_data[i]);
        OP_READ: begin
          apb_read(row_addr[i], rdata);
          check_word(row_name[i], row_exp[i], rdata);
        end
        OP_PINS: settle_pins(row_name[i], row_data[i]);
        OP_IRQ:  wait_irq(row_name[i], row_exp[i][0]);
        OP_PADS: begin
          // Drivers follow one edge after the last write
          @(negedge PCLK);
          check_word({row_name[i], "_out"}, row_data[i], gpio_out);
          check_word({row_name[i], "_oe"}, row_exp[i], gpio_oe);
        end
        default: ;
      endcase
    end
    $display("%0d rows, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/gpio_pkg.sv
design/gpio_apb_regs.sv
design/gpio_pad_ctrl.sv
design/gpio_trigger.sv
design/gpio_top.sv
bench/gpio_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_apb

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/gpio_pkg.sv
      - design/gpio_apb_regs.sv
      - design/gpio_pad_ctrl.sv
      - design/gpio_trigger.sv
      - design/gpio_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/gpio_tb.sv
